// File: source/rx_defines.svh
`ifndef RX_DEFINES_SVH
`define RX_DEFINES_SVH

// sample path
`define IQ_W        16
`define LLR_W       8
`define PHASE_W     20

// register access
`define AXI_ADDR_W  16
`define OFFSET_W    14
`define REG_W       32

// llr store entries, keep a power of two
`define LLR_DEPTH   16

`define N_ID_W      10

// identity word returned at CELL_ID
`define RX_ID_VALUE 32'h4E52_5358

`endif

// File: source/rx_pkg.sv
`include "rx_defines.svh"

package rx_pkg;

    // q in the upper half, i in the lower half
    typedef struct packed {
        logic [`IQ_W-1:0] q;
        logic [`IQ_W-1:0] i;
    } iq_t;

    typedef union packed {
        logic [2*`IQ_W-1:0] raw;
        iq_t                iq;
    } sample_u;

    typedef struct packed {
        logic              last;
        logic [`LLR_W-1:0] llr;
    } llr_entry_t;

    typedef logic signed [`PHASE_W-1:0] phase_t;
    typedef logic [`N_ID_W-1:0] n_id_t;
    typedef logic [1:0] n_id_2_t;

endpackage

// File: source/reg_pkg.sv
`include "rx_defines.svh"

package reg_pkg;

    // address bits 15:14
    typedef enum logic [1:0] {
        BLK_LLR  = 2'd0,
        BLK_CFO  = 2'd1,
        BLK_CELL = 2'd2,
        BLK_NONE = 2'd3
    } blk_sel_e;

    typedef struct packed {
        blk_sel_e              blk;
        logic [`OFFSET_W-1:0] offset;
    } reg_addr_t;

    // register word index inside a block, byte offset is index * 4
    typedef enum logic [1:0] {LLR_DATA, LLR_LEVEL, LLR_CLEAR} llr_reg_e;
    typedef enum logic {CFO_MODE, CFO_PHASE} cfo_reg_e;
    typedef enum logic [2:0] {CELL_ID, CELL_SAMPLE, CELL_NID2, CELL_NID, CELL_COUNT} cell_reg_e;

endpackage

// File: source/reg_bus_if.sv
`timescale 1ns/1ps
`include "rx_defines.svh"

interface reg_bus_if #(
    parameter int ADDR_W = `OFFSET_W
);
    logic [ADDR_W-1:0] addr;
    logic [`REG_W-1:0] wdata;
    logic              we;
    logic              re;
    // registered by the peer, valid the cycle after re
    logic [`REG_W-1:0] rdata;

    modport master (output addr, output wdata, output we, output re, input rdata);
    modport peer (input addr, input wdata, input we, input re, output rdata);

endinterface

// File: source/axil_reg_bridge.sv
`timescale 1ns/1ps
`include "rx_defines.svh"

module axil_reg_bridge (
    input  logic                   clk_i,
    input  logic                   reset_ni,

    input  logic [`AXI_ADDR_W-1:0] s_axil_awaddr_i,
    input  logic                   s_axil_awvalid_i,
    output logic                   s_axil_awready_o,
    input  logic [`REG_W-1:0]      s_axil_wdata_i,
    input  logic                   s_axil_wvalid_i,
    output logic                   s_axil_wready_o,
    output logic                   s_axil_bvalid_o,
    input  logic                   s_axil_bready_i,
    input  logic [`AXI_ADDR_W-1:0] s_axil_araddr_i,
    input  logic                   s_axil_arvalid_i,
    output logic                   s_axil_arready_o,
    output logic [`REG_W-1:0]      s_axil_rdata_o,
    output logic                   s_axil_rvalid_o,
    input  logic                   s_axil_rready_i,

    reg_bus_if.master              bus_o
);

    logic              wr_go_q;
    logic              rd_go_q;
    logic              rd_wait_q;
    logic              bvalid_q;
    logic              rvalid_q;
    logic [`REG_W-1:0] rdata_q;
    logic              wr_start;
    logic              rd_start;

    // writes win when both channels ask in the same cycle
    assign wr_start = s_axil_awvalid_i && s_axil_wvalid_i && !bvalid_q && !wr_go_q;
    assign rd_start = s_axil_arvalid_i && !rvalid_q && !rd_go_q && !rd_wait_q && !wr_start;

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            wr_go_q   <= 1'b0;
            rd_go_q   <= 1'b0;
            rd_wait_q <= 1'b0;
            bvalid_q  <= 1'b0;
            rvalid_q  <= 1'b0;
        end else begin
            wr_go_q   <= wr_start;
            rd_go_q   <= rd_start;
            rd_wait_q <= rd_go_q;
            if (wr_go_q) begin
                bvalid_q <= 1'b1;
            end else if (s_axil_bready_i) begin
                bvalid_q <= 1'b0;
            end
            if (rd_wait_q) begin
                rvalid_q <= 1'b1;
            end else if (s_axil_rready_i) begin
                rvalid_q <= 1'b0;
            end
        end
    end

    // peer data is on the bus one cycle after re
    always_ff @(posedge clk_i) begin
        if (rd_wait_q) begin
            rdata_q <= bus_o.rdata;
        end
    end

    // full address goes down, block bits included
    assign bus_o.addr  = wr_go_q ? s_axil_awaddr_i : s_axil_araddr_i;
    assign bus_o.wdata = s_axil_wdata_i;
    assign bus_o.we    = wr_go_q;
    assign bus_o.re    = rd_go_q;

    assign s_axil_awready_o = wr_go_q;
    assign s_axil_wready_o  = wr_go_q;
    assign s_axil_bvalid_o  = bvalid_q;
    assign s_axil_arready_o = rd_go_q;
    assign s_axil_rdata_o   = rdata_q;
    assign s_axil_rvalid_o  = rvalid_q;

endmodule

// File: source/reg_decoder.sv
`timescale 1ns/1ps

module reg_decoder (
    input  logic      clk_i,
    input  logic      reset_ni,
    reg_bus_if.peer   host_i,
    reg_bus_if.master llr_o,
    reg_bus_if.master cfo_o,
    reg_bus_if.master cell_o
);

    reg_pkg::reg_addr_t host_addr;
    reg_pkg::blk_sel_e  rd_sel_q;

    assign host_addr = host_i.addr;

    // remember which block the read went to
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            rd_sel_q <= reg_pkg::BLK_NONE;
        end else if (host_i.re) begin
            rd_sel_q <= host_addr.blk;
        end
    end

    // ------------------------------------------------------------------------
    // strobes to the selected peer only
    assign llr_o.addr   = host_addr.offset;
    assign llr_o.wdata  = host_i.wdata;
    assign llr_o.we     = host_i.we && (host_addr.blk == reg_pkg::BLK_LLR);
    assign llr_o.re     = host_i.re && (host_addr.blk == reg_pkg::BLK_LLR);

    assign cfo_o.addr   = host_addr.offset;
    assign cfo_o.wdata  = host_i.wdata;
    assign cfo_o.we     = host_i.we && (host_addr.blk == reg_pkg::BLK_CFO);
    assign cfo_o.re     = host_i.re && (host_addr.blk == reg_pkg::BLK_CFO);

    assign cell_o.addr  = host_addr.offset;
    assign cell_o.wdata = host_i.wdata;
    assign cell_o.we    = host_i.we && (host_addr.blk == reg_pkg::BLK_CELL);
    assign cell_o.re    = host_i.re && (host_addr.blk == reg_pkg::BLK_CELL);

    // ------------------------------------------------------------------------
    always_comb begin
        case (rd_sel_q)
            reg_pkg::BLK_LLR:  host_i.rdata = llr_o.rdata;
            reg_pkg::BLK_CFO:  host_i.rdata = cfo_o.rdata;
            reg_pkg::BLK_CELL: host_i.rdata = cell_o.rdata;
            default:           host_i.rdata = '0;
        endcase
    end

endmodule

// File: source/cfo_phase_tracker.sv
`timescale 1ns/1ps
`include "rx_defines.svh"

module cfo_phase_tracker (
    input  logic           clk_i,
    input  logic           reset_ni,
    reg_bus_if.peer        bus_i,
    input  logic           sample_valid_i,
    input  rx_pkg::phase_t cfo_inc_i,
    input  logic           cfo_valid_i,
    output rx_pkg::phase_t phase_o
);

    reg_pkg::cfo_reg_e reg_sel;
    logic              manual_q;
    rx_pkg::phase_t    inc_acc_q;
    rx_pkg::phase_t    phase_q;

    assign reg_sel = reg_pkg::cfo_reg_e'(bus_i.addr[2]);

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            manual_q  <= 1'b0;
            inc_acc_q <= '0;
            phase_q   <= '0;
        end else begin
            if (bus_i.we && reg_sel == reg_pkg::CFO_MODE) begin
                manual_q <= bus_i.wdata[0];
            end
            if (manual_q) begin
                inc_acc_q <= '0;
                phase_q   <= '0;
            end else begin
                // increments are relative to the previous estimate
                if (cfo_valid_i) begin
                    inc_acc_q <= inc_acc_q - cfo_inc_i;
                end
                if (sample_valid_i) begin
                    phase_q <= phase_q + inc_acc_q;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (bus_i.re) begin
            case (reg_sel)
                reg_pkg::CFO_MODE: bus_i.rdata <= {{(`REG_W-1){1'b0}}, manual_q};
                default:           bus_i.rdata <= {{(`REG_W-`PHASE_W){phase_q[`PHASE_W-1]}}, phase_q};
            endcase
        end
    end

    assign phase_o = phase_q;

endmodule

// File: source/cell_id_regs.sv
`timescale 1ns/1ps
`include "rx_defines.svh"

module cell_id_regs (
    input  logic            clk_i,
    input  logic            reset_ni,
    reg_bus_if.peer         bus_i,
    input  rx_pkg::sample_u sample_i,
    input  logic            sample_valid_i,
    input  rx_pkg::n_id_2_t n_id_2_i,
    input  logic            n_id_2_valid_i,
    input  rx_pkg::n_id_t   n_id_i,
    input  logic            n_id_valid_i
);

    reg_pkg::cell_reg_e reg_sel;
    logic [`REG_W-1:0]  count_q;
    rx_pkg::sample_u    sample_q;
    rx_pkg::n_id_2_t    n_id_2_q;
    rx_pkg::n_id_t      n_id_q;

    assign reg_sel = reg_pkg::cell_reg_e'(bus_i.addr[4:2]);

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            count_q  <= '0;
            n_id_2_q <= '0;
            n_id_q   <= '0;
        end else begin
            if (sample_valid_i) begin
                count_q <= count_q + 1'b1;
            end
            if (n_id_2_valid_i) begin
                n_id_2_q <= n_id_2_i;
            end
            if (n_id_valid_i) begin
                n_id_q <= n_id_i;
            end
        end
    end

    // last sample seen
    always_ff @(posedge clk_i) begin
        if (sample_valid_i) begin
            sample_q.raw <= sample_i.raw;
        end
    end

    // read only block
    always_ff @(posedge clk_i) begin
        if (bus_i.re) begin
            case (reg_sel)
                reg_pkg::CELL_ID:     bus_i.rdata <= `RX_ID_VALUE;
                reg_pkg::CELL_SAMPLE: bus_i.rdata <= sample_q.raw;
                reg_pkg::CELL_NID2:   bus_i.rdata <= `REG_W'(n_id_2_q);
                reg_pkg::CELL_NID:    bus_i.rdata <= `REG_W'(n_id_q);
                reg_pkg::CELL_COUNT:  bus_i.rdata <= count_q;
                default:              bus_i.rdata <= '0;
            endcase
        end
    end

endmodule

// File: source/llr_store.sv
`timescale 1ns/1ps
`include "rx_defines.svh"

module llr_store (
    input  logic              clk_i,
    input  logic              reset_ni,
    reg_bus_if.peer           bus_i,
    input  logic [`LLR_W-1:0] llr_data_i,
    input  logic [1:0]        llr_user_i,
    input  logic              llr_last_i,
    input  logic              llr_valid_i
);

    localparam int PTR_W = $clog2(`LLR_DEPTH);

    rx_pkg::llr_entry_t mem [`LLR_DEPTH];
    reg_pkg::llr_reg_e  reg_sel;
    logic [PTR_W-1:0]   wr_ptr_q;
    logic [PTR_W-1:0]   rd_ptr_q;
    logic [PTR_W:0]     level_q;
    logic               empty;
    logic               full;
    logic               push;
    logic               pop;
    logic               clear;

    assign reg_sel = reg_pkg::llr_reg_e'(bus_i.addr[3:2]);
    assign empty   = (level_q == '0);
    assign full    = (level_q == (PTR_W+1)'(`LLR_DEPTH));

    // pbch bits only, user code 1
    assign push  = llr_valid_i && (llr_user_i == 2'd1) && !full;
    assign pop   = bus_i.re && (reg_sel == reg_pkg::LLR_DATA) && !empty;
    assign clear = bus_i.we && (reg_sel == reg_pkg::LLR_CLEAR);

    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!reset_ni || clear) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            level_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({push, pop})
                2'b10:   level_q <= level_q + 1'b1;
                2'b01:   level_q <= level_q - 1'b1;
                default: level_q <= level_q;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (push && !clear) begin
            mem[wr_ptr_q] <= '{last: llr_last_i, llr: llr_data_i};
        end
    end

    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (bus_i.re) begin
            case (reg_sel)
                reg_pkg::LLR_DATA:  bus_i.rdata <= empty ? '0 : `REG_W'(mem[rd_ptr_q]);
                reg_pkg::LLR_LEVEL: bus_i.rdata <= `REG_W'(level_q);
                default:            bus_i.rdata <= '0;
            endcase
        end
    end

endmodule

// File: source/receiver_top.sv
`timescale 1ns/1ps
`include "rx_defines.svh"

module receiver_top (
    input  logic                   clk_i,
    input  logic                   reset_ni,

    input  logic [`IQ_W-1:0]       sample_i_i,
    input  logic [`IQ_W-1:0]       sample_q_i,
    input  logic                   sample_valid_i,
    input  rx_pkg::phase_t         cfo_inc_i,
    input  logic                   cfo_valid_i,
    input  rx_pkg::n_id_2_t        n_id_2_i,
    input  logic                   n_id_2_valid_i,
    input  rx_pkg::n_id_t          n_id_i,
    input  logic                   n_id_valid_i,
    input  logic [`LLR_W-1:0]      llr_data_i,
    input  logic [1:0]             llr_user_i,
    input  logic                   llr_last_i,
    input  logic                   llr_valid_i,

    // axi-lite slave
    input  logic [`AXI_ADDR_W-1:0] s_axil_awaddr_i,
    input  logic                   s_axil_awvalid_i,
    output logic                   s_axil_awready_o,
    input  logic [`REG_W-1:0]      s_axil_wdata_i,
    input  logic                   s_axil_wvalid_i,
    output logic                   s_axil_wready_o,
    output logic                   s_axil_bvalid_o,
    input  logic                   s_axil_bready_i,
    input  logic [`AXI_ADDR_W-1:0] s_axil_araddr_i,
    input  logic                   s_axil_arvalid_i,
    output logic                   s_axil_arready_o,
    output logic [`REG_W-1:0]      s_axil_rdata_o,
    output logic                   s_axil_rvalid_o,
    input  logic                   s_axil_rready_i,

    output rx_pkg::phase_t         cfo_phase_o
);

    rx_pkg::sample_u sample;

    reg_bus_if #(.ADDR_W(`AXI_ADDR_W)) host_bus ();
    reg_bus_if llr_bus ();
    reg_bus_if cfo_bus ();
    reg_bus_if cell_bus ();

    assign sample.iq = '{q: sample_q_i, i: sample_i_i};

    axil_reg_bridge bridge_i (
        .clk_i(clk_i),
        .reset_ni(reset_ni),
        .s_axil_awaddr_i(s_axil_awaddr_i),
        .s_axil_awvalid_i(s_axil_awvalid_i),
        .s_axil_awready_o(s_axil_awready_o),
        .s_axil_wdata_i(s_axil_wdata_i),
        .s_axil_wvalid_i(s_axil_wvalid_i),
        .s_axil_wready_o(s_axil_wready_o),
        .s_axil_bvalid_o(s_axil_bvalid_o),
        .s_axil_bready_i(s_axil_bready_i),
        .s_axil_araddr_i(s_axil_araddr_i),
        .s_axil_arvalid_i(s_axil_arvalid_i),
        .s_axil_arready_o(s_axil_arready_o),
        .s_axil_rdata_o(s_axil_rdata_o),
        .s_axil_rvalid_o(s_axil_rvalid_o),
        .s_axil_rready_i(s_axil_rready_i),
        .bus_o(host_bus)
    );

    reg_decoder decoder_i (
        .clk_i(clk_i),
        .reset_ni(reset_ni),
        .host_i(host_bus),
        .llr_o(llr_bus),
        .cfo_o(cfo_bus),
        .cell_o(cell_bus)
    );

    cfo_phase_tracker cfo_i (
        .clk_i(clk_i),
        .reset_ni(reset_ni),
        .bus_i(cfo_bus),
        .sample_valid_i(sample_valid_i),
        .cfo_inc_i(cfo_inc_i),
        .cfo_valid_i(cfo_valid_i),
        .phase_o(cfo_phase_o)
    );

    cell_id_regs cell_i (
        .clk_i(clk_i),
        .reset_ni(reset_ni),
        .bus_i(cell_bus),
        .sample_i(sample),
        .sample_valid_i(sample_valid_i),
        .n_id_2_i(n_id_2_i),
        .n_id_2_valid_i(n_id_2_valid_i),
        .n_id_i(n_id_i),
        .n_id_valid_i(n_id_valid_i)
    );

    llr_store llr_i (
        .clk_i(clk_i),
        .reset_ni(reset_ni),
        .bus_i(llr_bus),
        .llr_data_i(llr_data_i),
        .llr_user_i(llr_user_i),
        .llr_last_i(llr_last_i),
        .llr_valid_i(llr_valid_i)
    );

endmodule

// File: bench/receiver_tb.sv
`timescale 1ns/1ps
`include "rx_defines.svh"

module receiver_tb;

    localparam int CYCLE_LIMIT = 2000;

    // block select in bits 15:14, register index times four below
    localparam logic [15:0] LLR_DATA_A    = 16'h0000;
    localparam logic [15:0] LLR_LEVEL_A   = 16'h0004;
    localparam logic [15:0] LLR_CLEAR_A   = 16'h0008;
    localparam logic [15:0] CFO_MODE_A    = 16'h4000;
    localparam logic [15:0] CFO_PHASE_A   = 16'h4004;
    localparam logic [15:0] CELL_ID_A     = 16'h8000;
    localparam logic [15:0] CELL_SAMPLE_A = 16'h8004;
    localparam logic [15:0] CELL_NID2_A   = 16'h8008;
    localparam logic [15:0] CELL_NID_A    = 16'h800C;
    localparam logic [15:0] CELL_COUNT_A  = 16'h8010;
    localparam logic [15:0] UNMAPPED_A    = 16'hC000;

    logic               clk = 1'b0;
    logic               reset_n;
    logic [15:0]        sample_i;
    logic [15:0]        sample_q;
    logic               sample_valid;
    logic signed [19:0] cfo_inc;
    logic               cfo_valid;
    logic [1:0]         n_id_2;
    logic               n_id_2_valid;
    logic [9:0]         n_id;
    logic               n_id_valid;
    logic [7:0]         llr_data;
    logic [1:0]         llr_user;
    logic               llr_last;
    logic               llr_valid;
    logic [15:0]        awaddr;
    logic               awvalid;
    logic               awready;
    logic [31:0]        wdata;
    logic               wvalid;
    logic               wready;
    logic               bvalid;
    logic               bready;
    logic [15:0]        araddr;
    logic               arvalid;
    logic               arready;
    logic [31:0]        rdata;
    logic               rvalid;
    logic               rready;
    logic signed [19:0] cfo_phase;

    int          cycle_count = 0;
    int          error_count = 0;
    int          check_count = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          errors_at_start;
    string       test_name;
    logic [31:0] lcg_state;

    receiver_top dut_i (
        .clk_i(clk),
        .reset_ni(reset_n),
        .sample_i_i(sample_i),
        .sample_q_i(sample_q),
        .sample_valid_i(sample_valid),
        .cfo_inc_i(cfo_inc),
        .cfo_valid_i(cfo_valid),
        .n_id_2_i(n_id_2),
        .n_id_2_valid_i(n_id_2_valid),
        .n_id_i(n_id),
        .n_id_valid_i(n_id_valid),
        .llr_data_i(llr_data),
        .llr_user_i(llr_user),
        .llr_last_i(llr_last),
        .llr_valid_i(llr_valid),
        .s_axil_awaddr_i(awaddr),
        .s_axil_awvalid_i(awvalid),
        .s_axil_awready_o(awready),
        .s_axil_wdata_i(wdata),
        .s_axil_wvalid_i(wvalid),
        .s_axil_wready_o(wready),
        .s_axil_bvalid_o(bvalid),
        .s_axil_bready_i(bready),
        .s_axil_araddr_i(araddr),
        .s_axil_arvalid_i(arvalid),
        .s_axil_arready_o(arready),
        .s_axil_rdata_o(rdata),
        .s_axil_rvalid_o(rvalid),
        .s_axil_rready_i(rready),
        .cfo_phase_o(cfo_phase)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: tests did not finish within %0d cycles", CYCLE_LIMIT);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // drive and sample point is 2 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        assert (actual === expected) else begin
            $display("** Error %s, %s: expected 0x%08h, actual 0x%08h",
                     test_name, what, expected, actual);
            error_count++;
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        errors_at_start = error_count;
    endtask

    task automatic end_test();
        tests_run++;
        if (error_count == errors_at_start) begin
            $display("test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", test_name, error_count - errors_at_start);
        end
    endtask

    // ------------------------------------------------------------------------
    task automatic axil_write(input logic [15:0] addr, input logic [31:0] data);
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        next_cycle();
        while (!(awready && wready)) begin
            next_cycle();
        end
        // the transfer completes on the coming edge
        next_cycle();
        awvalid = 1'b0;
        wvalid  = 1'b0;
        bready  = 1'b1;
        while (!bvalid) begin
            next_cycle();
        end
        next_cycle();
        bready = 1'b0;
    endtask

    task automatic axil_read(input logic [15:0] addr, output logic [31:0] data);
        araddr  = addr;
        arvalid = 1'b1;
        next_cycle();
        while (!arready) begin
            next_cycle();
        end
        next_cycle();
        arvalid = 1'b0;
        rready  = 1'b1;
        while (!rvalid) begin
            next_cycle();
        end
        data = rdata;
        next_cycle();
        rready = 1'b0;
    endtask

    task automatic send_sample(input logic [15:0] i_val, input logic [15:0] q_val);
        sample_i     = i_val;
        sample_q     = q_val;
        sample_valid = 1'b1;
        next_cycle();
        sample_valid = 1'b0;
    endtask

    task automatic send_cfo(input logic signed [19:0] inc);
        cfo_inc   = inc;
        cfo_valid = 1'b1;
        next_cycle();
        cfo_valid = 1'b0;
    endtask

    task automatic send_n_id(input logic [1:0] nid2_val, input logic [9:0] nid_val);
        n_id_2       = nid2_val;
        n_id_2_valid = 1'b1;
        next_cycle();
        n_id_2_valid = 1'b0;
        n_id         = nid_val;
        n_id_valid   = 1'b1;
        next_cycle();
        n_id_valid   = 1'b0;
    endtask

    task automatic send_llr(input logic [7:0] value, input logic [1:0] user,
                            input logic last);
        llr_data  = value;
        llr_user  = user;
        llr_last  = last;
        llr_valid = 1'b1;
        next_cycle();
        llr_valid = 1'b0;
    endtask

    // ------------------------------------------------------------------------
    task automatic reset_value_test();
        logic [31:0] data;
        start_test("reset_values");
        axil_read(CELL_ID_A, data);
        check_value("cell id", `RX_ID_VALUE, data);
        axil_read(UNMAPPED_A, data);
        check_value("unmapped block", 32'h0, data);
        end_test();
    endtask

    task automatic sample_test();
        logic [31:0] r;
        logic [15:0] last_i;
        logic [15:0] last_q;
        logic [31:0] data;
        int          n;
        start_test("samples");
        for (n = 0; n < 10; n++) begin
            r = next_random();
            last_i = r[31:16];
            r = next_random();
            last_q = r[31:16];
            send_sample(last_i, last_q);
        end
        axil_read(CELL_COUNT_A, data);
        check_value("sample count", 32'd10, data);
        axil_read(CELL_SAMPLE_A, data);
        check_value("last sample", {last_q, last_i}, data);
        end_test();
    endtask

    task automatic n_id_test();
        logic [31:0] data;
        start_test("n_id");
        send_n_id(2'd2, 10'h1A5);
        axil_read(CELL_NID2_A, data);
        check_value("n_id_2 first", 32'd2, data);
        axil_read(CELL_NID_A, data);
        check_value("n_id first", 32'h1A5, data);
        // a later detection replaces the first
        send_n_id(2'd1, 10'h2F3);
        axil_read(CELL_NID2_A, data);
        check_value("n_id_2 second", 32'd1, data);
        axil_read(CELL_NID_A, data);
        check_value("n_id second", 32'h2F3, data);
        end_test();
    endtask

    task automatic cfo_test();
        int          a;
        int          b;
        int          expected;
        logic [31:0] data;
        logic [31:0] r;
        start_test("cfo");
        a = 37;
        b = -12;
        expected = -4 * a - 3 * (a + b);
        send_cfo(20'(a));
        repeat (4) begin
            r = next_random();
            send_sample(r[15:0], r[31:16]);
        end
        send_cfo(20'(b));
        repeat (3) begin
            r = next_random();
            send_sample(r[15:0], r[31:16]);
        end
        check_value("phase output", 32'(expected), {{12{cfo_phase[19]}}, cfo_phase});
        axil_read(CFO_PHASE_A, data);
        check_value("phase register", 32'(expected), data);
        axil_write(CFO_MODE_A, 32'd1);
        axil_read(CFO_PHASE_A, data);
        check_value("manual phase register", 32'h0, data);
        check_value("manual phase output", 32'h0, {{12{cfo_phase[19]}}, cfo_phase});
        end_test();
    endtask

    task automatic llr_test();
        logic [1:0]  user_codes [6] = '{2'd1, 2'd0, 2'd1, 2'd2, 2'd1, 2'd3};
        // kept entries carry both flag values
        logic        last_flags [6] = '{1'b1, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0};
        logic [8:0]  expected_q [$];
        logic [8:0]  entry;
        logic [31:0] r;
        logic [31:0] data;
        int          n;
        start_test("llr_store");
        for (n = 0; n < 6; n++) begin
            r = next_random();
            send_llr(r[31:24], user_codes[n], last_flags[n]);
            if (user_codes[n] == 2'd1) begin
                expected_q.push_back({last_flags[n], r[31:24]});
            end
        end
        axil_read(LLR_LEVEL_A, data);
        check_value("level after pushes", 32'(expected_q.size()), data);
        while (expected_q.size() > 0) begin
            entry = expected_q.pop_front();
            axil_read(LLR_DATA_A, data);
            check_value("llr entry", 32'(entry), data);
        end
        axil_read(LLR_DATA_A, data);
        check_value("empty read", 32'h0, data);
        send_llr(8'h5A, 2'd1, 1'b0);
        send_llr(8'hC3, 2'd1, 1'b1);
        axil_read(LLR_LEVEL_A, data);
        check_value("level before clear", 32'd2, data);
        axil_write(LLR_CLEAR_A, 32'd1);
        axil_read(LLR_LEVEL_A, data);
        check_value("level after clear", 32'h0, data);
        end_test();
    endtask

    // ------------------------------------------------------------------------
    initial begin
        lcg_state    = 32'd89292;
        reset_n      = 1'b0;
        sample_i     = '0;
        sample_q     = '0;
        sample_valid = 1'b0;
        cfo_inc      = '0;
        cfo_valid    = 1'b0;
        n_id_2       = '0;
        n_id_2_valid = 1'b0;
        n_id         = '0;
        n_id_valid   = 1'b0;
        llr_data     = '0;
        llr_user     = '0;
        llr_last     = 1'b0;
        llr_valid    = 1'b0;
        awaddr       = '0;
        awvalid      = 1'b0;
        wdata        = '0;
        wvalid       = 1'b0;
        bready       = 1'b0;
        araddr       = '0;
        arvalid      = 1'b0;
        rready       = 1'b0;
        repeat (2) @(posedge clk);
        #2;
        reset_n = 1'b1;

        reset_value_test();
        sample_test();
        n_id_test();
        cfo_test();
        llr_test();

        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, check_count, error_count);
        if (error_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: vlog.f
+incdir+source
source/rx_pkg.sv
source/reg_pkg.sv
source/reg_bus_if.sv
source/axil_reg_bridge.sv
source/reg_decoder.sv
source/cfo_phase_tracker.sv
source/cell_id_regs.sv
source/llr_store.sv
source/receiver_top.sv
bench/receiver_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the receiver testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
    --top-module receiver_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/Vreceiver_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "RESULT: FAIL" "$LOG"; then
    exit 1
fi
exit 0
